//--- filelist.f
logic/sys16_pkg.sv
logic/sys16_addr_decode.sv
logic/sys16_bus_ctrl.sv
logic/sys16_cab_io.sv
logic/sys16_ppi.sv
logic/sys16_vbl_irq.sv
logic/sys16_main.sv
tests/sys16_main_tb.sv

//--- logic/sys16_addr_decode.sv
// Memory map decoder
// Classifies the word address into a region on each start pulse
// and holds it for the rest of the bus cycle

`timescale 1ns/1ps

module sys16_addr_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [sys16_pkg::addr_w-1:0] wb_adr,
    input  logic                        start,
    output sys16_pkg::region_e          region
);
    import sys16_pkg::*;

    logic [1:0] hi;
    logic [2:0] mid;
    region_e    next_region;

    // Byte address bits 23:22 and 18:16
    assign hi  = wb_adr[22:21];
    assign mid = wb_adr[17:15];

    // First matching rule wins
    always_comb begin
        if (hi == 2'd0 && !mid[2])             next_region = reg_rom;
        else if (hi[0] && mid == 3'd0)         next_region = reg_vram;
        else if (hi[0] && mid == 3'd1)         next_region = reg_char;
        else if (hi == 2'd1 && mid[2])         next_region = reg_obj;
        else if (hi == 2'd2 && mid[2])         next_region = reg_pal;
        else if (hi == 2'd3 && mid[2:1] == 2'd2) next_region = reg_io;
        else if (hi == 2'd3 && mid == 3'd6)    next_region = reg_wdog;
        else if (hi == 2'd3 && mid == 3'd7)    next_region = reg_ram;
        else                                   next_region = reg_none;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region <= reg_none;
        end else if (start) begin
            region <= next_region;
        end
    end

    // A held start would reload the region in mid-cycle
    start_pulse: assert property (
        @(posedge clk) disable iff (rst) start |=> !start
    );

endmodule

//--- logic/sys16_bus_ctrl.sv
// Wishbone slave control FSM
// Chip selects, byte write strobes, wait states on the
// memory ok flags, read data capture and the ack pulse

`timescale 1ns/1ps

module sys16_bus_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [1:0]                  wb_sel,
    output logic                        wb_ack,
    output logic [sys16_pkg::data_w-1:0] wb_dat_r,
    input  sys16_pkg::region_e          region,
    output logic                        start,
    output logic                        rom_cs,
    output logic                        ram_cs,
    output logic                        vram_cs,
    output logic                        char_cs,
    output logic                        pal_cs,
    output logic                        objram_cs,
    output logic                        io_cs,
    output logic                        uds_wn,
    output logic                        lds_wn,
    input  logic [sys16_pkg::data_w-1:0] rom_data,
    input  logic                        rom_ok,
    input  logic [sys16_pkg::data_w-1:0] ram_data,
    input  logic                        ram_ok,
    input  logic [sys16_pkg::data_w-1:0] char_dout,
    input  logic [sys16_pkg::data_w-1:0] pal_dout,
    input  logic [sys16_pkg::data_w-1:0] obj_dout,
    input  logic [7:0]                  cab_dout
);
    import sys16_pkg::*;

    bus_state_e state;
    logic       mem_cs;
    logic       mem_ok;
    logic       done;

    // Decoder loads the region when idle sees a new strobe
    assign start  = (state == s_idle) && wb_cyc && wb_stb;
    assign wb_ack = (state == s_ack);

    // External memories stretch the cycle until ok
    assign mem_cs = rom_cs || ram_cs || vram_cs;
    assign mem_ok = rom_cs ? rom_ok : ram_ok;
    assign done   = !mem_cs || mem_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= s_idle;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            uds_wn    <= 1'b1;
            lds_wn    <= 1'b1;
        end else begin
            case (state)
                s_idle: begin
                    if (wb_cyc && wb_stb) state <= s_decode;
                end
                s_decode: begin
                    rom_cs    <= (region == reg_rom);
                    ram_cs    <= (region == reg_ram);
                    vram_cs   <= (region == reg_vram);
                    char_cs   <= (region == reg_char);
                    pal_cs    <= (region == reg_pal);
                    objram_cs <= (region == reg_obj);
                    io_cs     <= (region == reg_io);
                    uds_wn    <= !(wb_we && wb_sel[1]);
                    lds_wn    <= !(wb_we && wb_sel[0]);
                    state     <= s_wait;
                end
                s_wait: begin
                    if (done) state <= s_ack;
                end
                default: begin
                    // Selects drop together with ack
                    rom_cs    <= 1'b0;
                    ram_cs    <= 1'b0;
                    vram_cs   <= 1'b0;
                    char_cs   <= 1'b0;
                    pal_cs    <= 1'b0;
                    objram_cs <= 1'b0;
                    io_cs     <= 1'b0;
                    uds_wn    <= 1'b1;
                    lds_wn    <= 1'b1;
                    state     <= s_idle;
                end
            endcase
        end
    end

    // Read data captured on the edge that leaves s_wait
    always_ff @(posedge clk) begin
        if (state == s_wait && done) begin
            if (rom_cs)                wb_dat_r <= rom_data;
            else if (ram_cs || vram_cs) wb_dat_r <= ram_data;
            else if (char_cs)          wb_dat_r <= char_dout;
            else if (pal_cs)           wb_dat_r <= pal_dout;
            else if (objram_cs)        wb_dat_r <= obj_dout;
            else if (io_cs)            wb_dat_r <= {open_bus[15:8], cab_dout};
            else                       wb_dat_r <= open_bus;
        end
    end

    // Master must still hold the strobe when ack arrives
    ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb)
    );

    // Selects only stay up while the master holds the cycle
    select_in_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (rom_cs || ram_cs || vram_cs || char_cs || pal_cs || objram_cs || io_cs)
            |-> (wb_cyc && wb_stb)
    );

endmodule

//--- logic/sys16_cab_io.sv
// Cabinet I/O block
// Buttons, reordered joysticks and DIP switches on a registered
// read path, plus the select lines for the parallel port

`timescale 1ns/1ps

module sys16_cab_io (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        io_cs,
    input  logic [sys16_pkg::addr_w-1:0] wb_adr,
    input  logic                        wb_we,
    input  logic [7:0]                  joystick1,
    input  logic [7:0]                  joystick2,
    input  logic [1:0]                  start_button,
    input  logic [1:0]                  coin_input,
    input  logic                        service,
    input  logic [7:0]                  dipsw_a,
    input  logic [7:0]                  dipsw_b,
    output logic                        ppi_cs,
    output logic                        ppi_we,
    output logic [1:0]                  ppi_addr,
    input  logic [7:0]                  ppi_dout,
    output logic [7:0]                  cab_dout
);
    import sys16_pkg::*;

    logic [1:0] page;

    // Board wiring puts the joystick lines out of order
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1], joy[0], joy[3], joy[2], joy[7], joy[5], joy[4], joy[6]};
    endfunction

    // Byte address bits 13:12
    assign page = wb_adr[12:11];

    assign ppi_cs   = io_cs && (page == 2'd0);
    assign ppi_we   = wb_we;
    assign ppi_addr = wb_adr[1:0];

    // Address is stable from the strobe on, so the mux settles
    // well before the control FSM samples it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= open_bus[7:0];
        end else begin
            case (page)
                2'd0: cab_dout <= ppi_dout;
                2'd1: begin
                    case (wb_adr[1:0])
                        2'd0:    cab_dout <= {2'b11, start_button, service, 1'b1, coin_input};
                        2'd1:    cab_dout <= sort_joy(joystick1);
                        2'd3:    cab_dout <= sort_joy(joystick2);
                        default: cab_dout <= open_bus[7:0];
                    endcase
                end
                2'd2:    cab_dout <= wb_adr[0] ? dipsw_b : dipsw_a;
                default: cab_dout <= open_bus[7:0];
            endcase
        end
    end

endmodule

//--- logic/sys16_main.sv
// Main-board bus glue top level
// Wishbone slave in front of the address decoder, bus control FSM,
// cabinet I/O, parallel port and vertical-blank interrupt

`timescale 1ns/1ps

module sys16_main #(
    parameter int vbl_line = 223
) (
    input  logic                        clk,
    input  logic                        rst,
    // Wishbone slave
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [sys16_pkg::addr_w-1:0] wb_adr,
    input  logic [sys16_pkg::data_w-1:0] wb_dat_w,
    input  logic [1:0]                  wb_sel,
    output logic [sys16_pkg::data_w-1:0] wb_dat_r,
    output logic                        wb_ack,
    // Program ROM
    output logic                        rom_cs,
    output logic [16:0]                 rom_addr,
    input  logic [sys16_pkg::data_w-1:0] rom_data,
    input  logic                        rom_ok,
    // Work and video RAM
    output logic                        ram_cs,
    output logic                        vram_cs,
    input  logic [sys16_pkg::data_w-1:0] ram_data,
    input  logic                        ram_ok,
    output logic [sys16_pkg::data_w-1:0] cpu_dout,
    output logic                        uds_wn,
    output logic                        lds_wn,
    // Video memories
    output logic                        char_cs,
    output logic                        pal_cs,
    output logic                        objram_cs,
    input  logic [sys16_pkg::data_w-1:0] char_dout,
    input  logic [sys16_pkg::data_w-1:0] pal_dout,
    input  logic [sys16_pkg::data_w-1:0] obj_dout,
    output logic [11:0]                 cpu_addr,
    output logic                        flip,
    // Cabinet
    input  logic [7:0]                  joystick1,
    input  logic [7:0]                  joystick2,
    input  logic [1:0]                  start_button,
    input  logic [1:0]                  coin_input,
    input  logic                        service,
    input  logic [7:0]                  dipsw_a,
    input  logic [7:0]                  dipsw_b,
    // Sound
    output logic [7:0]                  snd_latch,
    output logic                        snd_irqn,
    input  logic                        snd_ack,
    // Video timing and interrupt
    input  logic [8:0]                  vdump,
    input  logic                        hstart,
    output logic                        irq_n,
    input  logic                        int_ack
);
    import sys16_pkg::*;

    region_e    region;
    logic       start;
    logic       io_cs;
    logic [7:0] cab_dout;
    logic       ppi_cs;
    logic       ppi_we;
    logic [1:0] ppi_addr;
    logic [7:0] ppi_dout;
    logic [7:0] portb;
    logic [7:0] portc;

    assign cpu_dout = wb_dat_w;
    assign rom_addr = wb_adr[16:0];
    assign cpu_addr = wb_adr[11:0];
    assign flip     = portb[7];
    assign snd_irqn = portc[7];

    sys16_addr_decode sys16_addr_decode_inst (
        .clk    (clk),
        .rst    (rst),
        .wb_adr (wb_adr),
        .start  (start),
        .region (region)
    );

    sys16_bus_ctrl sys16_bus_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_sel    (wb_sel),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .region    (region),
        .start     (start),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .uds_wn    (uds_wn),
        .lds_wn    (lds_wn),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout)
    );

    sys16_cab_io sys16_cab_io_inst (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .wb_adr       (wb_adr),
        .wb_we        (wb_we),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .ppi_cs       (ppi_cs),
        .ppi_we       (ppi_we),
        .ppi_addr     (ppi_addr),
        .ppi_dout     (ppi_dout),
        .cab_dout     (cab_dout)
    );

    // Sound latch on port A, sound ack read back on port C bit 6
    sys16_ppi sys16_ppi_inst (
        .clk       (clk),
        .rst       (rst),
        .ppi_cs    (ppi_cs),
        .ppi_we    (ppi_we),
        .ppi_addr  (ppi_addr),
        .din       (wb_dat_w[7:0]),
        .ppi_dout  (ppi_dout),
        .portc_in  (snd_ack),
        .porta_out (snd_latch),
        .portb_out (portb),
        .portc_out (portc)
    );

    sys16_vbl_irq #(
        .vbl_line (vbl_line)
    ) sys16_vbl_irq_inst (
        .clk     (clk),
        .rst     (rst),
        .vdump   (vdump),
        .hstart  (hstart),
        .int_ack (int_ack),
        .irq_n   (irq_n)
    );

endmodule

//--- logic/sys16_pkg.sv
// Shared definitions for the main-board bus glue
// Address and data widths, region and bus-state enums,
// open-bus value and parallel port reset values

package sys16_pkg;

    // Word address, byte address bits 23:1
    localparam int addr_w = 23;
    localparam int data_w = 16;

    // Region selected by one bus cycle
    typedef enum logic [3:0] {
        reg_none,
        reg_rom,
        reg_vram,
        reg_char,
        reg_obj,
        reg_pal,
        reg_io,
        reg_wdog,
        reg_ram
    } region_e;

    // Bus control FSM states
    typedef enum logic [1:0] {
        s_idle,
        s_decode,
        s_wait,
        s_ack
    } bus_state_e;

    // Returned for unmapped reads and the I/O upper byte
    localparam logic [data_w-1:0] open_bus = 16'hffff;

    // Port A is the sound latch, idles at all ones
    localparam logic [7:0] porta_rst = 8'hff;
    // Port B bit 7 is flip, screen starts upright
    localparam logic [7:0] portb_rst = 8'h00;
    // Port C bit 7 is the sound interrupt, active low
    localparam logic [7:0] portc_rst = 8'h80;

endpackage

//--- logic/sys16_ppi.sv
// 8255-style parallel port, mode 0 only
// Port A and B latches, port C latch with bit set/reset,
// combinational read back

`timescale 1ns/1ps

module sys16_ppi (
    input  logic       clk,
    input  logic       rst,
    input  logic       ppi_cs,
    input  logic       ppi_we,
    input  logic [1:0] ppi_addr,
    input  logic [7:0] din,
    output logic [7:0] ppi_dout,
    input  logic       portc_in,
    output logic [7:0] porta_out,
    output logic [7:0] portb_out,
    output logic [7:0] portc_out
);
    import sys16_pkg::*;

    logic wr;

    assign wr = ppi_cs && ppi_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            porta_out <= porta_rst;
            portb_out <= portb_rst;
            portc_out <= portc_rst;
        end else if (wr) begin
            case (ppi_addr)
                2'd0: porta_out <= din;
                2'd1: portb_out <= din;
                2'd2: portc_out <= din;
                default: begin
                    // Bit 7 set means a mode word, which is ignored
                    if (!din[7]) portc_out[din[3:1]] <= din[0];
                end
            endcase
        end
    end

    // Port C bit 6 is an input pin
    always_comb begin
        case (ppi_addr)
            2'd0:    ppi_dout = porta_out;
            2'd1:    ppi_dout = portb_out;
            2'd2:    ppi_dout = {portc_out[7], portc_in, portc_out[5:0]};
            default: ppi_dout = 8'hff;
        endcase
    end

endmodule

//--- logic/sys16_vbl_irq.sv
// Vertical-blank interrupt
// Edge detect on hstart, fires on the configured line,
// held low until the master acknowledges

`timescale 1ns/1ps

module sys16_vbl_irq #(
    parameter int vbl_line = 223
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vdump,
    input  logic       hstart,
    input  logic       int_ack,
    output logic       irq_n
);

    logic last_hstart;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hstart <= 1'b0;
            irq_n       <= 1'b1;
        end else begin
            last_hstart <= hstart;
            // Acknowledge wins over a new request
            if (int_ack) begin
                irq_n <= 1'b1;
            end else if (hstart && !last_hstart && vdump == 9'(vbl_line)) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the bus glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sys16_main_tb -f filelist.f -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- tests/sys16_main_tb.sv
// Testbench for the main-board bus glue
// ROM and RAM models with random ok delays, a Wishbone stimulus table
// applied in a loop, parallel port and vertical-blank interrupt checks

`timescale 1ns/1ps

module sys16_main_tb;
    import sys16_pkg::*;

    localparam int ack_limit = 20;
    localparam int irq_limit = 10;

    logic              clk;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [addr_w-1:0] wb_adr;
    logic [data_w-1:0] wb_dat_w;
    logic [1:0]        wb_sel;
    logic [data_w-1:0] wb_dat_r;
    logic              wb_ack;
    logic              rom_cs;
    logic [16:0]       rom_addr;
    logic [data_w-1:0] rom_data;
    logic              rom_ok;
    logic              ram_cs;
    logic              vram_cs;
    logic [data_w-1:0] ram_data;
    logic              ram_ok;
    logic [data_w-1:0] cpu_dout;
    logic              uds_wn;
    logic              lds_wn;
    logic              char_cs;
    logic              pal_cs;
    logic              objram_cs;
    logic [data_w-1:0] char_dout;
    logic [data_w-1:0] pal_dout;
    logic [data_w-1:0] obj_dout;
    logic [11:0]       cpu_addr;
    logic              flip;
    logic [7:0]        joystick1;
    logic [7:0]        joystick2;
    logic [1:0]        start_button;
    logic [1:0]        coin_input;
    logic              service;
    logic [7:0]        dipsw_a;
    logic [7:0]        dipsw_b;
    logic [7:0]        snd_latch;
    logic              snd_irqn;
    logic              snd_ack;
    logic [8:0]        vdump;
    logic              hstart;
    logic              irq_n;
    logic              int_ack;

    // Stimulus table columns
    logic        step_we[$];
    logic [23:0] step_addr[$];
    logic [15:0] step_data[$];
    logic [1:0]  step_sel[$];
    logic [15:0] step_exp[$];
    logic [5:0]  step_cs[$];
    string       step_name[$];

    int tests_run;
    int tests_failed;
    int seed;

    // Memory model state, one bus cycle in flight
    logic [15:0] ram_mem [0:63];
    logic [5:0]  ram_idx;
    logic [2:0]  mem_delay;
    logic [2:0]  mem_count;
    logic        mem_ready;

    always #2 clk = ~clk;

    sys16_main #(
        .vbl_line (223)
    ) sys16_main_inst (.*);

    // RAM and VRAM share the data bus, kept apart by index bit 5
    assign ram_idx   = {vram_cs, wb_adr[4:0]};
    assign rom_ok    = rom_cs && mem_ready;
    assign ram_ok    = (ram_cs || vram_cs) && mem_ready;
    assign rom_data  = rom_ok ? (rom_addr[15:0] ^ 16'h5a5a) : 16'h0000;
    assign ram_data  = ram_ok ? ram_mem[ram_idx] : 16'h0000;
    assign char_dout = {4'hc, cpu_addr};
    assign pal_dout  = {4'h9, cpu_addr};
    assign obj_dout  = {4'hb, cpu_addr};

    function automatic logic [15:0] fill_word(input int idx);
        return 16'(idx) * 16'h0301 + 16'h1e0f;
    endfunction

    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) ram_mem[i] = fill_word(i);
            mem_ready <= 1'b0;
            mem_count <= 3'd0;
        end else if (!(rom_cs || ram_cs || vram_cs)) begin
            mem_ready <= 1'b0;
            mem_count <= mem_delay;
        end else if (mem_count != 3'd0) begin
            mem_count <= mem_count - 3'd1;
        end else if (!mem_ready) begin
            mem_ready <= 1'b1;
            // Byte lanes land when ok goes up
            if ((ram_cs || vram_cs) && !uds_wn) ram_mem[ram_idx][15:8] = cpu_dout[15:8];
            if ((ram_cs || vram_cs) && !lds_wn) ram_mem[ram_idx][7:0] = cpu_dout[7:0];
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] t=%0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name, input logic ok);
        tests_run++;
        if (ok) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic add_step(input logic we, input logic [23:0] addr, input logic [15:0] data,
                            input logic [1:0] sel, input logic [15:0] exp,
                            input logic [5:0] cs, input string name);
        step_we.push_back(we);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_sel.push_back(sel);
        step_exp.push_back(exp);
        step_cs.push_back(cs);
        step_name.push_back(name);
    endtask

    // Byte addresses; selects are {rom, ram, vram, char, pal, obj}
    task automatic build_table;
        add_step(0, 24'h000000, 16'h0000, 2'b11, 16'h5a5a, 6'b100000, "rom_read_0");
        add_step(0, 24'h001234, 16'h0000, 2'b11, 16'h5340, 6'b100000, "rom_read_1234");
        add_step(0, 24'h03abce, 16'h0000, 2'b11, 16'h8fbd, 6'b100000, "rom_read_3abce");
        add_step(0, 24'h02fffe, 16'h0000, 2'b11, 16'h25a5, 6'b100000, "rom_read_2fffe");
        add_step(1, 24'hc70010, 16'h1234, 2'b11, 16'h0000, 6'b010000, "ram_write_word");
        add_step(1, 24'hc70010, 16'habcd, 2'b10, 16'h0000, 6'b010000, "ram_write_upper");
        add_step(0, 24'hc70010, 16'h0000, 2'b11, 16'hab34, 6'b010000, "ram_read_upper");
        add_step(1, 24'hc70010, 16'h5e6f, 2'b01, 16'h0000, 6'b010000, "ram_write_lower");
        add_step(0, 24'hc70010, 16'h0000, 2'b11, 16'hab6f, 6'b010000, "ram_read_lower");
        add_step(1, 24'h400020, 16'h0f1e, 2'b11, 16'h0000, 6'b001000, "vram_write_word");
        add_step(1, 24'h400020, 16'h7788, 2'b01, 16'h0000, 6'b001000, "vram_write_lower");
        add_step(1, 24'h400020, 16'h9999, 2'b00, 16'h0000, 6'b001000, "vram_write_none");
        add_step(0, 24'h400020, 16'h0000, 2'b11, 16'h0f88, 6'b001000, "vram_read_merged");
        add_step(0, 24'hc70010, 16'h0000, 2'b11, 16'hab6f, 6'b010000, "ram_read_again");
        add_step(0, 24'h410246, 16'h0000, 2'b11, 16'hc123, 6'b000100, "char_read");
        add_step(0, 24'h440a08, 16'h0000, 2'b11, 16'hb504, 6'b000001, "obj_read");
        add_step(0, 24'h840ffe, 16'h0000, 2'b11, 16'h97ff, 6'b000010, "pal_read");
        add_step(0, 24'h800000, 16'h0000, 2'b11, 16'hffff, 6'b000000, "unmapped_read");
        add_step(0, 24'hc60000, 16'h0000, 2'b11, 16'hffff, 6'b000000, "wdog_read");
        add_step(1, 24'hc60000, 16'h1111, 2'b11, 16'h0000, 6'b000000, "wdog_write");
        add_step(0, 24'hc41000, 16'h0000, 2'b11, 16'hffe5, 6'b000000, "io_buttons");
        add_step(0, 24'hc41002, 16'h0000, 2'b11, 16'hff1e, 6'b000000, "io_joystick1");
        add_step(0, 24'hc41004, 16'h0000, 2'b11, 16'hffff, 6'b000000, "io_word2");
        add_step(0, 24'hc41006, 16'h0000, 2'b11, 16'hffa5, 6'b000000, "io_joystick2");
        add_step(0, 24'hc42000, 16'h0000, 2'b11, 16'hff3c, 6'b000000, "io_dipsw_a");
        add_step(0, 24'hc42002, 16'h0000, 2'b11, 16'hffd2, 6'b000000, "io_dipsw_b");
        add_step(0, 24'hc43000, 16'h0000, 2'b11, 16'hffff, 6'b000000, "io_page3");
        add_step(1, 24'hc40000, 16'h0037, 2'b01, 16'h0000, 6'b000000, "ppi_write_porta");
        add_step(0, 24'hc40000, 16'h0000, 2'b11, 16'hff37, 6'b000000, "ppi_read_porta");
        add_step(1, 24'hc40002, 16'h0080, 2'b01, 16'h0000, 6'b000000, "ppi_write_portb");
        add_step(0, 24'hc40002, 16'h0000, 2'b11, 16'hff80, 6'b000000, "ppi_read_portb");
        add_step(0, 24'hc40004, 16'h0000, 2'b11, 16'hffc0, 6'b000000, "ppi_read_portc_rst");
        add_step(1, 24'hc40006, 16'h000e, 2'b01, 16'h0000, 6'b000000, "ppi_clear_pc7");
        add_step(0, 24'hc40004, 16'h0000, 2'b11, 16'hff40, 6'b000000, "ppi_read_portc_clr");
        add_step(1, 24'hc40006, 16'h009b, 2'b01, 16'h0000, 6'b000000, "ppi_mode_word");
        add_step(1, 24'hc40006, 16'h0001, 2'b01, 16'h0000, 6'b000000, "ppi_set_pc0");
        add_step(0, 24'hc40004, 16'h0000, 2'b11, 16'hff41, 6'b000000, "ppi_read_portc_set");
    endtask

    task automatic bus_cycle(input logic we, input logic [23:0] addr, input logic [15:0] data,
                             input logic [1:0] sel, input logic [5:0] exp_cs,
                             output logic [15:0] rdata, output logic [5:0] cs_seen,
                             output logic stray, output logic got);
        int         count;
        logic [5:0] cs_now;
        mem_delay = 3'($urandom % 6);
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = addr[23:1];
        wb_dat_w  = data;
        wb_sel    = sel;
        count     = 0;
        got       = 1'b0;
        stray     = 1'b0;
        rdata     = 16'h0000;
        cs_seen   = 6'd0;
        while (!got && count < ack_limit) begin
            @(negedge clk);
            count++;
            cs_now = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};
            if ((cs_now & ~exp_cs) != 6'd0) stray = 1'b1;
            if (wb_ack) begin
                got     = 1'b1;
                rdata   = wb_dat_r;
                cs_seen = cs_now;
            end
        end
        // Strobe stays up through the edge that closes the ack
        if (got) @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic run_table;
        logic [15:0] rdata;
        logic [5:0]  cs_seen;
        logic        stray;
        logic        got;
        logic        ok;
        for (int i = 0; i < step_name.size(); i++) begin
            bus_cycle(step_we[i], step_addr[i], step_data[i], step_sel[i], step_cs[i],
                      rdata, cs_seen, stray, got);
            ok = 1'b1;
            if (!got) begin
                $display("Timeout: no bus acknowledge within %0d cycles in %s",
                         ack_limit, step_name[i]);
                ok = 1'b0;
            end else begin
                if (!step_we[i] && rdata !== step_exp[i]) begin
                    report_error($sformatf("%s read 0x%04h, expected 0x%04h",
                                           step_name[i], rdata, step_exp[i]));
                    ok = 1'b0;
                end
                if (cs_seen !== step_cs[i]) begin
                    report_error($sformatf("%s chip selects %b at ack, expected %b",
                                           step_name[i], cs_seen, step_cs[i]));
                    ok = 1'b0;
                end
                if (stray) begin
                    report_error($sformatf("%s raised another chip select", step_name[i]));
                    ok = 1'b0;
                end
            end
            end_test(step_name[i], ok);
        end
    endtask

    task automatic check_reset_state;
        logic ok;
        ok = 1'b1;
        if (wb_ack !== 1'b0 || {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs} !== 6'd0) begin
            report_error("ack or chip select active after reset");
            ok = 1'b0;
        end
        if (uds_wn !== 1'b1 || lds_wn !== 1'b1) begin
            report_error("write strobes active after reset");
            ok = 1'b0;
        end
        if (irq_n !== 1'b1 || snd_irqn !== 1'b1 || flip !== 1'b0 || snd_latch !== 8'hff) begin
            report_error("irq_n, snd_irqn, flip or snd_latch wrong after reset");
            ok = 1'b0;
        end
        end_test("reset_state", ok);
    endtask

    task automatic check_ppi_outputs;
        logic ok;
        ok = 1'b1;
        if (snd_latch !== 8'h37) begin
            report_error($sformatf("snd_latch 0x%02h, expected 0x37", snd_latch));
            ok = 1'b0;
        end
        if (flip !== 1'b1) begin
            report_error("flip low after port B write of 0x80");
            ok = 1'b0;
        end
        if (snd_irqn !== 1'b0) begin
            report_error("snd_irqn high after port C bit 7 reset");
            ok = 1'b0;
        end
        end_test("ppi_outputs", ok);
    endtask

    task automatic pulse_hstart(input logic [8:0] line);
        vdump  = line;
        hstart = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_irq(input logic level, output logic seen);
        int count;
        count = 0;
        while (irq_n !== level && count < irq_limit) begin
            @(negedge clk);
            count++;
        end
        seen = (irq_n === level);
    endtask

    task automatic check_vbl;
        logic ok;
        logic seen;
        ok = 1'b1;
        pulse_hstart(9'd100);
        wait_irq(1'b0, seen);
        if (seen) begin
            report_error("irq_n fell on line 100");
            ok = 1'b0;
        end
        end_test("vbl_other_line", ok);
        ok = 1'b1;
        pulse_hstart(9'd223);
        wait_irq(1'b0, seen);
        if (!seen) begin
            $display("Timeout: irq_n did not fall after hstart on line 223");
            ok = 1'b0;
        end
        end_test("vbl_line_223", ok);
        ok = 1'b1;
        int_ack = 1'b1;
        @(negedge clk);
        int_ack = 1'b0;
        wait_irq(1'b1, seen);
        if (!seen) begin
            $display("Timeout: irq_n did not return high after int_ack");
            ok = 1'b0;
        end
        end_test("vbl_int_ack", ok);
    endtask

    initial begin
        seed         = $urandom(61);
        clk          = 1'b0;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = 2'b00;
        joystick1    = 8'hb4;
        joystick2    = 8'h6a;
        start_button = 2'b10;
        coin_input   = 2'b01;
        service      = 1'b0;
        dipsw_a      = 8'h3c;
        dipsw_b      = 8'hd2;
        snd_ack      = 1'b1;
        vdump        = 9'd0;
        hstart       = 1'b0;
        int_ack      = 1'b0;
        mem_delay    = 3'd0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        build_table();
        run_table();
        check_ppi_outputs();
        check_vbl();
        $display("Summary: %0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
